// File: link_health_monitor.sv
`default_nettype none

module link_health_monitor (
  input  logic       clk,
  input  logic       s_axis_aresetn,
  input  logic       rx_block_lock_i,
  input  logic       disable_wd_i,
  link_status_if.mon status
);

  // Lock synchronizer chain, oldest sample at the top
  logic [status_pkg::SYNC_STAGES-1:0]  sync_q;
  logic                                link_up;
  // Previous link_up for loss detection
  logic                                link_up_q;

  // Recent link_up samples, newest in bit 0
  logic [status_pkg::LOCK_HISTORY-1:0] history;
  logic                                hist_zero;
  logic                                hist_ones;
  // Qualified rising edge of the lock
  logic                                edge_hit;

  // Low signal watchdog
  logic [status_pkg::WD_WIDTH-1:0]     wd_cnt;
  logic                                wd_match;

  // --------------------------------------------------
  // Lock synchronizer
  // --------------------------------------------------

  // rx_block_lock_i comes from the GT recovered clock
  always_ff @(posedge clk) begin
    if (!s_axis_aresetn) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[status_pkg::SYNC_STAGES-2:0], rx_block_lock_i};
    end
  end

  assign link_up        = sync_q[status_pkg::SYNC_STAGES-1];
  assign status.link_up = link_up;

  // --------------------------------------------------
  // Edge reset pulse
  // --------------------------------------------------

  assign hist_zero = ~|history;
  assign hist_ones = &history;
  // Rise after a full window of low samples
  // Short glitches leave ones in the window and are ignored
  assign edge_hit  = status.link_rst_n & hist_zero & link_up;

  always_ff @(posedge clk) begin
    if (!s_axis_aresetn) begin
      history           <= '0;
      status.link_rst_n <= 1'b1;
    end else begin
      // Edge sample is dropped from the window, release then needs
      // LOCK_HISTORY high samples taken while the reset is held
      history <= {history[status_pkg::LOCK_HISTORY-2:0], link_up & ~edge_hit};

      if (edge_hit) begin
        status.link_rst_n <= 1'b0;
      end else if (!status.link_rst_n && hist_ones && link_up) begin
        status.link_rst_n <= 1'b1;
      end
    end
  end

  // --------------------------------------------------
  // Watchdog
  // --------------------------------------------------

  // Match on the upper bits only, stretches the pulse
  assign wd_match = ~|wd_cnt[status_pkg::WD_WIDTH-1:status_pkg::WD_LOW_BITS];

  always_ff @(posedge clk) begin
    if (!s_axis_aresetn) begin
      wd_cnt          <= '1;
      status.wd_rst_n <= 1'b1;
    end else if (disable_wd_i) begin
      // Parked at max, no pulses
      wd_cnt          <= '1;
      status.wd_rst_n <= 1'b1;
    end else begin
      // Good link keeps reloading, lost link counts down and wraps
      if (link_up) begin
        wd_cnt <= '1;
      end else begin
        wd_cnt <= wd_cnt - 1'b1;
      end
      status.wd_rst_n <= ~wd_match;
    end
  end

  // --------------------------------------------------
  // Loss counter
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (!s_axis_aresetn) begin
      link_up_q         <= 1'b0;
      status.loss_count <= '0;
    end else begin
      link_up_q <= link_up;
      // One count per falling edge
      if (link_up_q && !link_up) begin
        status.loss_count <= status.loss_count + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: link_status.f
status_pkg.sv
status_ifs.sv
stream_activity_monitor.sv
link_health_monitor.sv
status_led_driver.sv
link_status_top.sv
tb_link_status.sv

// File: link_status_top.sv
`default_nettype none

module link_status_top (
  input  logic                  clk,
  input  logic                  s_axis_aresetn,

  // Slave stream from the MAC
  input  status_pkg::data_t     s_axis_tdata_i,
  input  status_pkg::keep_t     s_axis_tkeep_i,
  input  logic                  s_axis_tvalid_i,
  input  logic                  s_axis_tlast_i,
  output logic                  s_axis_tready_o,

  // Master stream towards the switch
  output status_pkg::data_t     m_axis_tdata_o,
  output status_pkg::keep_t     m_axis_tkeep_o,
  output logic                  m_axis_tvalid_o,
  output logic                  m_axis_tlast_o,
  input  logic                  m_axis_tready_i,

  // Link and LED controls
  input  logic                  rx_block_lock_i,
  input  logic                  disable_wd_i,
  input  status_pkg::led_mode_e led_mode_i,
  input  logic [1:0]            led_gpio_i,

  // Status
  output status_pkg::led_t      led_o,
  output logic                  sop_o,
  output logic                  req_suppress_o,
  output logic                  link_rst_n_o,
  output logic                  wd_rst_n_o
);

  stream_status_if stream_if ();
  link_status_if   link_if ();

  // --------------------------------------------------
  // Stream pass-through
  // --------------------------------------------------

  // Data flow is untouched, only the control flags are tapped
  assign m_axis_tdata_o  = s_axis_tdata_i;
  assign m_axis_tkeep_o  = s_axis_tkeep_i;
  assign m_axis_tvalid_o = s_axis_tvalid_i;
  assign m_axis_tlast_o  = s_axis_tlast_i;
  assign s_axis_tready_o = m_axis_tready_i;

  // --------------------------------------------------
  // Monitors
  // --------------------------------------------------

  // tready taken from the master side, the real acceptance point
  stream_activity_monitor u_stream_mon (
    .clk            (clk),
    .s_axis_aresetn (s_axis_aresetn),
    .tvalid_i       (s_axis_tvalid_i),
    .tready_i       (m_axis_tready_i),
    .tlast_i        (s_axis_tlast_i),
    .status         (stream_if.mon)
  );

  link_health_monitor u_link_mon (
    .clk             (clk),
    .s_axis_aresetn  (s_axis_aresetn),
    .rx_block_lock_i (rx_block_lock_i),
    .disable_wd_i    (disable_wd_i),
    .status          (link_if.mon)
  );

  status_led_driver u_led (
    .clk            (clk),
    .s_axis_aresetn (s_axis_aresetn),
    .led_mode_i     (led_mode_i),
    .led_gpio_i     (led_gpio_i),
    .stream         (stream_if.led),
    .link           (link_if.led),
    .led_o          (led_o)
  );

  // Flat status ports for the block design
  assign sop_o          = stream_if.sop;
  assign req_suppress_o = stream_if.suppress;
  assign link_rst_n_o   = link_if.link_rst_n;
  assign wd_rst_n_o     = link_if.wd_rst_n;

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
  --top-module tb_link_status -f link_status.f -o sim_link_status &&
  ./obj_dir/sim_link_status | tee /dev/stderr | grep -q "^all tests passed$" &&
  echo "Simulation PASS" ||
  { echo "Simulation FAIL"; exit 1; }

// File: status_ifs.sv
`default_nettype none

// --------------------------------------------------
// Stream monitor results
// --------------------------------------------------

interface stream_status_if;

  // One cycle pulse after the first accepted beat of a frame
  logic sop;
  // High between first and last accepted beat
  logic in_frame;
  // Arbitration suppress request to the stream switch
  logic suppress;
  // Frames seen since reset, wraps
  status_pkg::count_t frame_count;

  // Stream monitor drives everything
  modport mon (
    output sop,
    output in_frame,
    output suppress,
    output frame_count
  );

  // LED driver only looks
  modport led (
    input sop,
    input in_frame,
    input suppress,
    input frame_count
  );

endinterface

// --------------------------------------------------
// Link monitor results
// --------------------------------------------------

interface link_status_if;

  // Block lock after the synchronizer
  logic link_up;
  // Active low reset pulse on a qualified lock rise
  logic link_rst_n;
  // Active low watchdog reset while lock stays low
  logic wd_rst_n;
  // Falling edges of link_up since reset, wraps
  status_pkg::count_t loss_count;

  modport mon (
    output link_up,
    output link_rst_n,
    output wd_rst_n,
    output loss_count
  );

  modport led (
    input link_up,
    input link_rst_n,
    input wd_rst_n,
    input loss_count
  );

endinterface

`default_nettype wire

// File: status_led_driver.sv
`default_nettype none

module status_led_driver (
  input  logic                  clk,
  input  logic                  s_axis_aresetn,
  input  status_pkg::led_mode_e led_mode_i,
  input  logic [1:0]            led_gpio_i,
  stream_status_if.led          stream,
  link_status_if.led            link,
  output status_pkg::led_t      led_o
);

  // Word selected for the next cycle
  status_pkg::led_t led_next;

  // --------------------------------------------------
  // Source select
  // --------------------------------------------------

  always_comb begin
    case (led_mode_i)
      status_pkg::LED_COUNTS: begin
        // Losses on the upper nibble, frames on the lower
        led_next = {link.loss_count[3:0], stream.frame_count[3:0]};
      end
      status_pkg::LED_LIVE: begin
        // Bit 7 always lit, shows the board is configured
        // Reset bits are shown active high
        led_next = {1'b1,
                    stream.suppress,
                    stream.in_frame,
                    ~link.link_rst_n,
                    ~link.wd_rst_n,
                    led_gpio_i,
                    link.link_up};
      end
      default: begin
        led_next = '0;
      end
    endcase
  end

  // --------------------------------------------------
  // Output register
  // --------------------------------------------------

  // Registered so the pads see a clean level
  always_ff @(posedge clk) begin
    if (!s_axis_aresetn) begin
      led_o <= '0;
    end else begin
      led_o <= led_next;
    end
  end

endmodule

`default_nettype wire

// File: status_pkg.sv
`default_nettype none

package status_pkg;

  // --------------------------------------------------
  // Stream widths
  // --------------------------------------------------

  // 10G MAC side data path
  localparam int DATA_W = 64;
  // One enable per byte lane
  localparam int KEEP_W = DATA_W / 8;

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [KEEP_W-1:0] keep_t;

  // Front panel LED word
  typedef logic [7:0] led_t;

  // Wrapping event count, frames and lock losses
  typedef logic [7:0] count_t;

  // --------------------------------------------------
  // Timing constants
  // --------------------------------------------------

  // Idle beats before the switch may arbitrate again
  localparam int IDLE_CYCLES = 8;
  // Wide enough to hold IDLE_CYCLES when saturated
  localparam int IDLE_CNT_W = 4;

  // Lock samples needed to qualify a rising edge
  localparam int LOCK_HISTORY = 10;

  // Watchdog period is 2**WD_WIDTH cycles, short for simulation
  localparam int WD_WIDTH = 8;
  // Ignored low bits, pulse is 2**WD_LOW_BITS cycles wide
  localparam int WD_LOW_BITS = 2;

  // Flops in the lock synchronizer
  localparam int SYNC_STAGES = 2;

  // LED source select
  typedef enum logic {
    LED_LIVE   = 1'b0,
    LED_COUNTS = 1'b1
  } led_mode_e;

endpackage

`default_nettype wire

// File: stream_activity_monitor.sv
`default_nettype none

module stream_activity_monitor (
  input  logic         clk,
  input  logic         s_axis_aresetn,
  input  logic         tvalid_i,
  input  logic         tready_i,
  input  logic         tlast_i,
  stream_status_if.mon status
);

  // Beat handshake
  logic                              accept;
  // Accepted beat that opens a frame
  logic                              first_beat;

  // Consecutive tvalid low cycles, saturates at IDLE_CYCLES
  logic [status_pkg::IDLE_CNT_W-1:0] idle_cnt;
  // Current idle cycle is the last one needed
  logic                              idle_last;
  // Counter has reached its ceiling
  logic                              idle_full;

  // --------------------------------------------------
  // Frame boundaries
  // --------------------------------------------------

  // Only observed, the monitor never touches tready
  assign accept     = tvalid_i & tready_i;
  assign first_beat = accept & ~status.in_frame;

  always_ff @(posedge clk) begin
    if (!s_axis_aresetn) begin
      status.sop         <= 1'b0;
      status.in_frame    <= 1'b0;
      status.frame_count <= '0;
    end else begin
      // Stalled first beat is not accepted, so no pulse yet
      status.sop <= first_beat;

      // Single beat frame leaves in_frame low
      if (accept) begin
        status.in_frame <= ~tlast_i;
      end

      // Count moves together with sop
      if (first_beat) begin
        status.frame_count <= status.frame_count + 1'b1;
      end
    end
  end

  // --------------------------------------------------
  // Arbitration suppress
  // --------------------------------------------------

  // Idle cycle number IDLE_CYCLES sees IDLE_CYCLES-1 already counted
  assign idle_last = ~tvalid_i &
                     (idle_cnt == status_pkg::IDLE_CNT_W'(status_pkg::IDLE_CYCLES - 1));
  assign idle_full = (idle_cnt == status_pkg::IDLE_CNT_W'(status_pkg::IDLE_CYCLES));

  always_ff @(posedge clk) begin
    if (!s_axis_aresetn) begin
      idle_cnt <= '0;
    end else if (tvalid_i) begin
      // Any valid beat restarts the idle run, accepted or not
      idle_cnt <= '0;
    end else if (!idle_full) begin
      idle_cnt <= idle_cnt + 1'b1;
    end
  end

  // Set on tvalid, held through back-pressure
  // Cleared only once a full idle run has been seen
  always_ff @(posedge clk) begin
    if (!s_axis_aresetn) begin
      status.suppress <= 1'b0;
    end else if (tvalid_i) begin
      status.suppress <= 1'b1;
    end else if (idle_last) begin
      status.suppress <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: tb_link_status.sv
`default_nettype none

module tb_link_status;
  timeunit 1ns;
  timeprecision 1ps;

  // Cycle budget per phase, timeout is the sum plus a margin
  localparam int RAND_FRAMES  = 24;
  localparam int FRAME_BUDGET = 60;
  localparam int WD_HOLD      = 600;
  localparam int LIMIT        = 2 * RAND_FRAMES * FRAME_BUDGET + 2 * (WD_HOLD + 40) + 600;

  logic                  clk = 1'b0;
  logic                  s_axis_aresetn;
  status_pkg::data_t     s_axis_tdata_i;
  status_pkg::data_t     m_axis_tdata_o;
  status_pkg::keep_t     s_axis_tkeep_i;
  status_pkg::keep_t     m_axis_tkeep_o;
  logic                  s_axis_tvalid_i, s_axis_tlast_i, s_axis_tready_o;
  logic                  m_axis_tvalid_o, m_axis_tlast_o, m_axis_tready_i;
  logic                  rx_block_lock_i, disable_wd_i;
  status_pkg::led_mode_e led_mode_i;
  logic [1:0]            led_gpio_i;
  status_pkg::led_t      led_o;
  logic                  sop_o, req_suppress_o, link_rst_n_o, wd_rst_n_o;

  // Reference model, values expected right after the last edge
  logic               m_sop, m_in_frame, m_sup, m_sync1, m_up, m_up_prev, m_rst_n, m_wd_n;
  status_pkg::count_t m_frames, m_losses;
  status_pkg::led_t   m_led;
  int                 m_idle, m_low_run, m_rst_left, m_wd_run;

  logic [31:0] rng = 32'd5845;
  logic        stall_en = 1'b0;
  logic        beat_taken, rst_prev = 1'b1, wd_prev = 1'b1;
  int          cycles = 0, errors = 0, err_mark = 0, tests_run = 0, tests_bad = 0;
  int          frames_sent = 0, lock_drops = 0, sop_seen = 0;
  int          rst_falls = 0, rst_low = 0, wd_falls = 0, wd_low = 0;
  int          mark_a, mark_b;

  link_status_top DUT (.*);

  always #10 clk = ~clk;

  // --------------------------------------------------
  // Reference functions
  // --------------------------------------------------

  function automatic logic [31:0] rand_next();
    logic [31:0] x;
    x   = rng;
    x   = x ^ (x << 13);
    x   = x ^ (x >> 17);
    x   = x ^ (x << 5);
    rng = x;
    return x;
  endfunction

  function automatic status_pkg::led_t led_expect(
    input status_pkg::led_mode_e mode,
    input logic [1:0]            gpio,
    input logic                  up, wd_n, rst_n, in_frame, sup,
    input status_pkg::count_t    frames, losses
  );
    if (mode == status_pkg::LED_COUNTS) begin
      return {losses[3:0], frames[3:0]};
    end
    // Reset bits lit while active
    return {1'b1, sup, in_frame, !rst_n, !wd_n, gpio, up};
  endfunction

  // High unless run sits in the last few cycles of a watchdog period
  function automatic logic wd_expect(input int run);
    int period;
    int width;
    period = 1 << status_pkg::WD_WIDTH;
    width  = 1 << status_pkg::WD_LOW_BITS;
    return (run % period) < (period - width);
  endfunction

  // --------------------------------------------------
  // Reference model, updated on each rising edge
  // --------------------------------------------------

  always @(posedge clk) begin
    if (!s_axis_aresetn) begin
      m_led      = '0;
      m_sop      = 1'b0;
      m_in_frame = 1'b0;
      m_frames   = '0;
      m_idle     = 0;
      m_sup      = 1'b0;
      m_sync1    = 1'b0;
      m_up       = 1'b0;
      m_up_prev  = 1'b0;
      // Cleared history looks like a long loss
      m_low_run  = status_pkg::LOCK_HISTORY;
      m_rst_left = 0;
      m_rst_n    = 1'b1;
      m_wd_run   = 0;
      m_wd_n     = 1'b1;
      m_losses   = '0;
    end else begin
      // LED shows sources from before this edge
      m_led = led_expect(led_mode_i, led_gpio_i, m_up, m_wd_n, m_rst_n,
                         m_in_frame, m_sup, m_frames, m_losses);
      // Frame boundaries from accepted beats only
      m_sop = s_axis_tvalid_i && m_axis_tready_i && !m_in_frame;
      if (m_sop) m_frames = m_frames + 8'd1;
      if (s_axis_tvalid_i && m_axis_tready_i) m_in_frame = !s_axis_tlast_i;
      // Suppress ends on the eighth idle cycle in a row
      if (s_axis_tvalid_i) begin
        m_idle = 0;
        m_sup  = 1'b1;
      end else begin
        m_idle++;
        if (m_idle == status_pkg::IDLE_CYCLES) m_sup = 1'b0;
      end
      // Rise after a full low window gives an 11 cycle pulse
      if (m_rst_left > 0) begin
        m_rst_left--;
      end else if (m_up && m_low_run >= status_pkg::LOCK_HISTORY) begin
        m_rst_left = status_pkg::LOCK_HISTORY + 1;
      end
      m_rst_n   = (m_rst_left == 0);
      m_low_run = m_up ? 0 : m_low_run + 1;
      // Watchdog phase counts low lock samples
      m_wd_n   = disable_wd_i || wd_expect(m_wd_run);
      m_wd_run = (disable_wd_i || m_up) ? 0 : m_wd_run + 1;
      if (m_up_prev && !m_up) m_losses = m_losses + 8'd1;
      m_up_prev = m_up;
      // Two stage lock delay
      m_up    = m_sync1;
      m_sync1 = rx_block_lock_i;
    end
  end

  // --------------------------------------------------
  // Comparing process, mid cycle
  // --------------------------------------------------

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
    end
  endtask

  always @(negedge clk) begin
    if (cycles > 0) begin
      check("m_axis_tdata_o", m_axis_tdata_o, s_axis_tdata_i);
      check("m_axis_tkeep_o", m_axis_tkeep_o, s_axis_tkeep_i);
      check("m_axis_tvalid_o", m_axis_tvalid_o, s_axis_tvalid_i);
      check("m_axis_tlast_o", m_axis_tlast_o, s_axis_tlast_i);
      check("s_axis_tready_o", s_axis_tready_o, m_axis_tready_i);
      check("sop_o", sop_o, m_sop);
      check("req_suppress_o", req_suppress_o, m_sup);
      check("link_rst_n_o", link_rst_n_o, m_rst_n);
      check("wd_rst_n_o", wd_rst_n_o, m_wd_n);
      check("led_o", led_o, m_led);
      // Pulse bookkeeping for the per test checks
      if (sop_o === 1'b1) sop_seen++;
      if (link_rst_n_o === 1'b0) rst_low++;
      if (rst_prev && link_rst_n_o === 1'b0) rst_falls++;
      if (wd_rst_n_o === 1'b0) wd_low++;
      if (wd_prev && wd_rst_n_o === 1'b0) wd_falls++;
      rst_prev = link_rst_n_o;
      wd_prev  = wd_rst_n_o;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= LIMIT) begin
      $display("Timeout: stimulus still running after %0d cycles", cycles);
      $display("tests failed");
      $finish;
    end
  end

  // --------------------------------------------------
  // Stimulus tasks
  // --------------------------------------------------

  task automatic end_test(input string name);
    int bad;
    bad = errors - err_mark;
    tests_run++;
    if (bad != 0) begin
      tests_bad++;
      $display("Test %0d %s: FAIL with %0d mismatches", tests_run, name, bad);
    end else begin
      $display("Test %0d %s: ok", tests_run, name);
    end
    err_mark = errors;
  endtask

  // One clock, inputs change 2 ns after the edge
  task automatic tick();
    logic [31:0] r;
    @(posedge clk);
    beat_taken = s_axis_tvalid_i & s_axis_tready_o;
    #2;
    if (stall_en) begin
      r               = rand_next();
      m_axis_tready_i = (r[1:0] != 2'b00);
    end
  endtask

  task automatic idle(input int n);
    s_axis_tvalid_i = 1'b0;
    s_axis_tlast_i  = 1'b0;
    repeat (n) tick();
  endtask

  task automatic send_frame(input int len, input int hold);
    for (int i = 0; i < len; i++) begin
      s_axis_tdata_i  = {rand_next(), rand_next()};
      s_axis_tkeep_i  = (i == len - 1) ? status_pkg::keep_t'(rand_next()) : '1;
      s_axis_tvalid_i = 1'b1;
      s_axis_tlast_i  = (i == len - 1);
      if (i == 0 && hold > 0) begin
        // First beat offered with tready low
        m_axis_tready_i = 1'b0;
        repeat (hold) tick();
        m_axis_tready_i = 1'b1;
      end
      do begin
        tick();
      end while (!beat_taken);
    end
    idle(0);
    frames_sent++;
  endtask

  task automatic lock_low(input int n);
    rx_block_lock_i = 1'b0;
    lock_drops++;
    repeat (n) tick();
    rx_block_lock_i = 1'b1;
    repeat (40) tick();
  endtask

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------

  initial begin
    logic [31:0] r;
    $timeformat(-9, 0, " ns", 0);
    s_axis_aresetn  = 1'b0;
    s_axis_tdata_i  = '0;
    s_axis_tkeep_i  = '0;
    s_axis_tvalid_i = 1'b0;
    s_axis_tlast_i  = 1'b0;
    m_axis_tready_i = 1'b1;
    rx_block_lock_i = 1'b1;
    disable_wd_i    = 1'b0;
    led_mode_i      = status_pkg::LED_LIVE;
    led_gpio_i      = 2'b00;
    repeat (3) @(posedge clk);
    #2;
    s_axis_aresetn = 1'b1;
    // Lock comes up, one edge pulse expected
    repeat (20) tick();

    stall_en = 1'b1;
    for (int f = 0; f < RAND_FRAMES; f++) begin
      r = rand_next();
      send_frame(1 + r[2:0], 0);
      idle(r[11:8]);
    end
    stall_en        = 1'b0;
    m_axis_tready_i = 1'b1;
    // Last sop lands before the next count starts
    idle(2);
    end_test("pass-through");

    led_mode_i = status_pkg::LED_COUNTS;
    mark_a     = sop_seen;
    send_frame(1, 0);
    send_frame(1, 2);
    for (int f = 0; f < RAND_FRAMES; f++) begin
      r = rand_next();
      send_frame(1 + r[1:0], r[9:8]);
      idle(r[14:12]);
    end
    idle(2);
    check("sop pulses", sop_seen - mark_a, RAND_FRAMES + 2);
    check("led_o frame nibble", led_o[3:0], frames_sent % 16);
    end_test("start of packet");

    idle(10);
    check("req_suppress_o", req_suppress_o, 0);
    send_frame(3, 0);
    idle(7);
    check("req_suppress_o", req_suppress_o, 1);
    send_frame(1, 0);
    idle(7);
    check("req_suppress_o", req_suppress_o, 1);
    idle(1);
    check("req_suppress_o", req_suppress_o, 0);
    // Back-pressure keeps suppress up
    send_frame(1, 5);
    idle(8);
    check("req_suppress_o", req_suppress_o, 0);
    end_test("suppress");

    mark_a = rst_falls;
    mark_b = rst_low;
    lock_low(20);
    lock_low(5);
    check("link_rst_n_o pulses", rst_falls - mark_a, 1);
    check("link_rst_n_o low cycles", rst_low - mark_b, status_pkg::LOCK_HISTORY + 1);
    check("led_o loss nibble", led_o[7:4], lock_drops % 16);
    end_test("edge pulse");

    mark_a = wd_falls;
    mark_b = wd_low;
    lock_low(WD_HOLD);
    check("wd_rst_n_o pulses", wd_falls - mark_a, 2);
    check("wd_rst_n_o low cycles", wd_low - mark_b, 8);
    disable_wd_i = 1'b1;
    mark_a       = wd_falls;
    lock_low(WD_HOLD);
    disable_wd_i = 1'b0;
    check("wd_rst_n_o pulses", wd_falls - mark_a, 0);
    end_test("watchdog");

    led_mode_i = status_pkg::LED_LIVE;
    for (int g = 0; g < 4; g++) begin
      led_gpio_i = g[1:0];
      tick();
      check("led_o gpio bits", led_o[2:1], g);
      check("led_o bit 7", led_o[7], 1);
    end
    send_frame(6, 2);
    lock_low(12);
    end_test("led live");

    $display("Summary: %0d tests run, %0d with mismatches, %0d mismatches in total",
             tests_run, tests_bad, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
